// ==== include/mips_defs.svh ====
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// Boot ROM entry point, first fetch after reset
`define MIPS_RESET_VECTOR 32'hBFC00000

// Jump-register target that stops the core
`define MIPS_HALT_ADDR 32'h00000000

// Link register for JAL and the REGIMM link branches
`define MIPS_REG_RA 5'd31

// Result register exposed as register_v0
`define MIPS_REG_V0 5'd2

`endif

// ==== verilog/mips_isa_pkg.sv ====
`default_nettype none

package mips_isa_pkg;

	// Primary opcode field, bits 31:26
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'h00, // R-type, decoded by funct
		OP_REGIMM  = 6'h01, // Sign branches, decoded by rt
		OP_J       = 6'h02,
		OP_JAL     = 6'h03,
		OP_BEQ     = 6'h04,
		OP_BNE     = 6'h05,
		OP_BLEZ    = 6'h06,
		OP_BGTZ    = 6'h07,
		OP_ADDIU   = 6'h09,
		OP_SLTI    = 6'h0A,
		OP_SLTIU   = 6'h0B,
		OP_ANDI    = 6'h0C,
		OP_ORI     = 6'h0D,
		OP_XORI    = 6'h0E,
		OP_LUI     = 6'h0F,
		OP_LW      = 6'h23,
		OP_SW      = 6'h2B
	} opcode_e;

	// SPECIAL funct field, bits 5:0
	typedef enum logic [5:0] {
		FN_SLL  = 6'h00,
		FN_SRL  = 6'h02,
		FN_SRA  = 6'h03,
		FN_SLLV = 6'h04,
		FN_SRLV = 6'h06,
		FN_SRAV = 6'h07,
		FN_JR   = 6'h08,
		FN_JALR = 6'h09,
		FN_ADDU = 6'h21,
		FN_SUBU = 6'h23,
		FN_AND  = 6'h24,
		FN_OR   = 6'h25,
		FN_XOR  = 6'h26,
		FN_SLT  = 6'h2A,
		FN_SLTU = 6'h2B
	} funct_e;

	// REGIMM branch selector carried in rt
	typedef enum logic [4:0] {
		RI_BLTZ   = 5'h00,
		RI_BGEZ   = 5'h01,
		RI_BLTZAL = 5'h10,
		RI_BGEZAL = 5'h11
	} regimm_e;

	typedef struct packed {
		opcode_e    opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		funct_e     funct;
	} r_fmt_s;

	typedef struct packed {
		opcode_e     opcode;
		logic [4:0]  rs;
		logic [4:0]  rt; // Also the REGIMM selector
		logic [15:0] imm16;
	} i_fmt_s;

	typedef struct packed {
		opcode_e     opcode;
		logic [25:0] target26; // Word index within the 256MB region
	} j_fmt_s;

	// Same fetched word, three field layouts
	typedef union packed {
		r_fmt_s r;
		i_fmt_s i;
		j_fmt_s j;
	} instr_word_u;

endpackage

`default_nettype wire

// ==== verilog/cpu_ctrl_pkg.sv ====
`default_nettype none

package cpu_ctrl_pkg;

	typedef enum logic [3:0] {
		ALU_ADD, // Wrapping add, also address calc
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_NOR,
		ALU_SLT,  // Signed compare
		ALU_SLTU, // Unsigned compare
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_LUI   // imm16 into upper half
	} alu_op_e;

	// Compare applied to rs (and rt for EQ/NE)
	typedef enum logic [2:0] {
		BR_NONE, BR_EQ, BR_NE, BR_LEZ, BR_GTZ, BR_LTZ, BR_GEZ
	} branch_cond_e;

	typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_LINK} wb_src_e;

	typedef enum logic [1:0] {PC_SEQ, PC_BRANCH, PC_JUMP, PC_JREG} pc_sel_e;

	typedef enum logic [1:0] {DEST_RT, DEST_RD, DEST_RA} dest_sel_e;

	// All zero is a harmless no-op
	typedef struct packed {
		logic         reg_write;
		dest_sel_e    dest_sel;
		logic         alu_src_imm;  // Operand B from immediate
		logic         imm_zero_ext; // Logic immediates
		logic         shift_var;    // Shift amount from rs
		alu_op_e      alu_op;
		branch_cond_e branch_cond;
		pc_sel_e      pc_sel;
		wb_src_e      wb_src;
		logic         mem_read;
		logic         mem_write;
		logic         illegal;
	} ctrl_s;

endpackage

`default_nettype wire

// ==== verilog/instr_decoder.sv ====
`default_nettype none

module instr_decoder (
	input  mips_isa_pkg::instr_word_u instr,
	output cpu_ctrl_pkg::ctrl_s       ctrl
);
	import mips_isa_pkg::*;
	import cpu_ctrl_pkg::*;

	always_comb begin
		ctrl = '0; // ALU_ADD, BR_NONE, PC_SEQ, WB_ALU, DEST_RT
		case (instr.i.opcode)
			OP_SPECIAL: begin
				ctrl.reg_write = 1'b1;
				ctrl.dest_sel  = DEST_RD;
				case (instr.r.funct)
					FN_ADDU: ctrl.alu_op = ALU_ADD;
					FN_SUBU: ctrl.alu_op = ALU_SUB;
					FN_AND:  ctrl.alu_op = ALU_AND;
					FN_OR:   ctrl.alu_op = ALU_OR;
					FN_XOR:  ctrl.alu_op = ALU_XOR;
					FN_SLT:  ctrl.alu_op = ALU_SLT;
					FN_SLTU: ctrl.alu_op = ALU_SLTU;
					FN_SLL:  ctrl.alu_op = ALU_SLL;
					FN_SRL:  ctrl.alu_op = ALU_SRL;
					FN_SRA:  ctrl.alu_op = ALU_SRA;
					FN_SLLV: begin
						ctrl.alu_op    = ALU_SLL;
						ctrl.shift_var = 1'b1;
					end
					FN_SRLV: begin
						ctrl.alu_op    = ALU_SRL;
						ctrl.shift_var = 1'b1;
					end
					FN_SRAV: begin
						ctrl.alu_op    = ALU_SRA;
						ctrl.shift_var = 1'b1;
					end
					FN_JR: begin
						ctrl.reg_write = 1'b0; // Plain jump, nothing linked
						ctrl.pc_sel    = PC_JREG;
					end
					FN_JALR: begin
						ctrl.pc_sel = PC_JREG;
						ctrl.wb_src = WB_LINK; // Link into rd
					end
					default: ctrl.illegal = 1'b1;
				endcase
			end
			OP_REGIMM: begin
				ctrl.pc_sel = PC_BRANCH;
				case (regimm_e'(instr.i.rt))
					RI_BLTZ: ctrl.branch_cond = BR_LTZ;
					RI_BGEZ: ctrl.branch_cond = BR_GEZ;
					RI_BLTZAL, RI_BGEZAL: begin
						// Link is written whether or not taken
						ctrl.branch_cond = instr.i.rt[0] ? BR_GEZ : BR_LTZ;
						ctrl.reg_write   = 1'b1;
						ctrl.dest_sel    = DEST_RA;
						ctrl.wb_src      = WB_LINK;
					end
					default: ctrl.illegal = 1'b1;
				endcase
			end
			OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ: begin
				ctrl.pc_sel = PC_BRANCH;
				case (instr.i.opcode)
					OP_BEQ:  ctrl.branch_cond = BR_EQ;
					OP_BNE:  ctrl.branch_cond = BR_NE;
					OP_BLEZ: ctrl.branch_cond = BR_LEZ;
					default: ctrl.branch_cond = BR_GTZ;
				endcase
			end
			OP_J: ctrl.pc_sel = PC_JUMP;
			OP_JAL: begin
				ctrl.pc_sel    = PC_JUMP;
				ctrl.reg_write = 1'b1;
				ctrl.dest_sel  = DEST_RA;
				ctrl.wb_src    = WB_LINK;
			end
			OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
				ctrl.reg_write   = 1'b1;
				ctrl.alu_src_imm = 1'b1;
				case (instr.i.opcode)
					OP_SLTI:  ctrl.alu_op = ALU_SLT;
					OP_SLTIU: ctrl.alu_op = ALU_SLTU; // Sign-extended, compared unsigned
					OP_ANDI:  ctrl.alu_op = ALU_AND;
					OP_ORI:   ctrl.alu_op = ALU_OR;
					OP_XORI:  ctrl.alu_op = ALU_XOR;
					OP_LUI:   ctrl.alu_op = ALU_LUI;
					default:  ctrl.alu_op = ALU_ADD;
				endcase
				ctrl.imm_zero_ext = (instr.i.opcode inside {OP_ANDI, OP_ORI, OP_XORI});
			end
			OP_LW: begin
				ctrl.reg_write   = 1'b1;
				ctrl.alu_src_imm = 1'b1; // base + offset
				ctrl.mem_read    = 1'b1;
				ctrl.wb_src      = WB_MEM;
			end
			OP_SW: begin
				ctrl.alu_src_imm = 1'b1;
				ctrl.mem_write   = 1'b1;
			end
			default: ctrl.illegal = 1'b1;
		endcase
		if (ctrl.illegal) begin
			// Unknown word retires as a no-op
			ctrl.reg_write = 1'b0;
			ctrl.mem_read  = 1'b0;
			ctrl.mem_write = 1'b0;
			ctrl.pc_sel    = PC_SEQ;
		end
	end

	// Unknown fetch words are tolerated but flagged
	assert final (!ctrl.illegal || $isunknown(instr))
		else $warning("illegal instruction %h", instr);

endmodule

`default_nettype wire

// ==== verilog/register_file.sv ====
`default_nettype none
`include "mips_defs.svh"

module register_file (
	input  logic        clk,
	input  logic        reset,
	input  logic        wr_en,
	input  logic [4:0]  wr_addr,
	input  logic [4:0]  rd_addr_a,
	input  logic [4:0]  rd_addr_b,
	input  logic [31:0] wr_data,
	output logic [31:0] rd_data_a,
	output logic [31:0] rd_data_b,
	output logic [31:0] v0
);
	logic [31:0] regs [1:31]; // r0 has no storage

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end else if (wr_en && wr_addr != 5'd0) begin
			regs[wr_addr] <= wr_data;
		end
	end

	assign rd_data_a = (rd_addr_a == 5'd0) ? '0 : regs[rd_addr_a]; // Read before same-edge write
	assign rd_data_b = (rd_addr_b == 5'd0) ? '0 : regs[rd_addr_b];
	assign v0 = regs[`MIPS_REG_V0];

	// Committed writes carry a known address and value
	assert property (@(posedge clk) disable iff (reset)
		wr_en |-> !$isunknown({wr_addr, wr_data}))
		else $error("register write with unknown address or data");

endmodule

`default_nettype wire

// ==== verilog/execute_unit.sv ====
`default_nettype none

module execute_unit (
	input  cpu_ctrl_pkg::ctrl_s       ctrl,
	input  mips_isa_pkg::instr_word_u instr,
	input  logic [31:0]               rs_data,
	input  logic [31:0]               rt_data,
	output logic [31:0]               alu_result,
	output logic                      branch_taken
);
	import cpu_ctrl_pkg::*;

	logic [31:0] imm_ext;
	logic [31:0] op_b;
	logic [4:0]  shamt;
	logic        rs_zero;
	logic        rs_neg;

	assign imm_ext = ctrl.imm_zero_ext ? {16'h0000, instr.i.imm16}
		: {{16{instr.i.imm16[15]}}, instr.i.imm16};
	assign op_b  = ctrl.alu_src_imm ? imm_ext : rt_data;
	assign shamt = ctrl.shift_var ? rs_data[4:0] : instr.r.shamt; // Only low 5 bits of rs count

	always_comb begin
		case (ctrl.alu_op)
			ALU_ADD:  alu_result = rs_data + op_b; // No overflow trap
			ALU_SUB:  alu_result = rs_data - op_b;
			ALU_AND:  alu_result = rs_data & op_b;
			ALU_OR:   alu_result = rs_data | op_b;
			ALU_XOR:  alu_result = rs_data ^ op_b;
			ALU_NOR:  alu_result = ~(rs_data | op_b);
			ALU_SLT:  alu_result = {31'd0, $signed(rs_data) < $signed(op_b)};
			ALU_SLTU: alu_result = {31'd0, rs_data < op_b};
			ALU_SLL:  alu_result = op_b << shamt; // Shifts act on rt
			ALU_SRL:  alu_result = op_b >> shamt;
			ALU_SRA:  alu_result = $unsigned($signed(op_b) >>> shamt);
			ALU_LUI:  alu_result = {instr.i.imm16, 16'h0000};
			default:  alu_result = '0;
		endcase
	end

	// Branch compare kept off the ALU path
	assign rs_zero = (rs_data == '0);
	assign rs_neg  = rs_data[31];

	always_comb begin
		case (ctrl.branch_cond)
			BR_EQ:   branch_taken = (rs_data == rt_data);
			BR_NE:   branch_taken = (rs_data != rt_data);
			BR_LEZ:  branch_taken = rs_neg || rs_zero;
			BR_GTZ:  branch_taken = !rs_neg && !rs_zero;
			BR_LTZ:  branch_taken = rs_neg;
			BR_GEZ:  branch_taken = !rs_neg;
			default: branch_taken = 1'b0; // Not a branch
		endcase
	end

endmodule

`default_nettype wire

// ==== verilog/commit_unit.sv ====
`default_nettype none
`include "mips_defs.svh"

module commit_unit (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      clk_enable,
	input  cpu_ctrl_pkg::ctrl_s       ctrl,
	input  mips_isa_pkg::instr_word_u instr,
	input  logic [31:0]               rs_data,
	input  logic [31:0]               alu_result,
	input  logic [31:0]               mem_rdata,
	input  logic                      branch_taken,
	output logic [31:0]               pc,
	output logic                      active,
	output logic                      wb_en,
	output logic [4:0]                wb_addr,
	output logic [31:0]               wb_data,
	output logic                      mem_read,
	output logic                      mem_write
);
	import cpu_ctrl_pkg::*;

	logic [31:0] pc_plus4;
	logic [31:0] branch_target;
	logic [31:0] jump_target;
	logic [31:0] pc_next;
	logic        halting;

	assign pc_plus4      = pc + 32'd4; // Also the link value, no delay slot
	assign branch_target = pc_plus4 + {{14{instr.i.imm16[15]}}, instr.i.imm16, 2'b00};
	assign jump_target   = {pc_plus4[31:28], instr.j.target26, 2'b00};

	always_comb begin
		case (ctrl.pc_sel)
			PC_BRANCH: pc_next = branch_taken ? branch_target : pc_plus4;
			PC_JUMP:   pc_next = jump_target;
			PC_JREG:   pc_next = rs_data;
			default:   pc_next = pc_plus4;
		endcase
	end

	assign halting = active && ctrl.pc_sel == PC_JREG && rs_data == `MIPS_HALT_ADDR;

	// PC and run flag move together, frozen by stall or halt
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pc     <= `MIPS_RESET_VECTOR;
			active <= 1'b1;
		end else if (clk_enable && active) begin
			pc <= pc_next;
			if (halting)
				active <= 1'b0;
		end
	end

	always_comb begin
		case (ctrl.dest_sel)
			DEST_RD: wb_addr = instr.r.rd;
			DEST_RA: wb_addr = `MIPS_REG_RA;
			default: wb_addr = instr.i.rt;
		endcase
		case (ctrl.wb_src)
			WB_MEM:  wb_data = mem_rdata;
			WB_LINK: wb_data = pc_plus4;
			default: wb_data = alu_result;
		endcase
	end

	assign wb_en     = ctrl.reg_write && active && clk_enable; // Commit only on enabled edge
	assign mem_read  = ctrl.mem_read && active;
	assign mem_write = ctrl.mem_write && active; // Held across stalls, memory samples clk_enable

	// Fetch address stays word aligned while running
	assert property (@(posedge clk) disable iff (reset) active |-> pc[1:0] == 2'b00)
		else $error("misaligned pc %h", pc);

endmodule

`default_nettype wire

// ==== verilog/mips_cpu_harvard.sv ====
`default_nettype none

module mips_cpu_harvard (
	input  logic        clk,
	input  logic        reset,
	output logic        active,
	output logic [31:0] register_v0,
	input  logic        clk_enable,
	output logic [31:0] instr_address,
	input  logic [31:0] instr_readdata,
	output logic [31:0] data_address,
	output logic        data_write,
	output logic        data_read,
	output logic [31:0] data_writedata,
	input  logic [31:0] data_readdata
);
	import mips_isa_pkg::*;
	import cpu_ctrl_pkg::*;

	instr_word_u instr;
	ctrl_s       ctrl;
	logic [31:0] rs_data;
	logic [31:0] rt_data;
	logic [31:0] alu_result;
	logic        branch_taken;
	logic        wb_en;
	logic [4:0]  wb_addr;
	logic [31:0] wb_data;

	assign instr = instr_readdata; // Fetch returns within the cycle

	instr_decoder u_decoder (
		.instr (instr),
		.ctrl  (ctrl)
	);

	register_file u_regs (
		.clk       (clk),
		.reset     (reset),
		.wr_en     (wb_en),
		.wr_addr   (wb_addr),
		.rd_addr_a (instr.r.rs),
		.rd_addr_b (instr.r.rt),
		.wr_data   (wb_data),
		.rd_data_a (rs_data),
		.rd_data_b (rt_data),
		.v0        (register_v0)
	);

	execute_unit u_execute (
		.ctrl         (ctrl),
		.instr        (instr),
		.rs_data      (rs_data),
		.rt_data      (rt_data),
		.alu_result   (alu_result),
		.branch_taken (branch_taken)
	);

	commit_unit u_commit (
		.clk          (clk),
		.reset        (reset),
		.clk_enable   (clk_enable),
		.ctrl         (ctrl),
		.instr        (instr),
		.rs_data      (rs_data),
		.alu_result   (alu_result),
		.mem_rdata    (data_readdata),
		.branch_taken (branch_taken),
		.pc           (instr_address),
		.active       (active),
		.wb_en        (wb_en),
		.wb_addr      (wb_addr),
		.wb_data      (wb_data),
		.mem_read     (data_read),
		.mem_write    (data_write)
	);

	assign data_address   = alu_result; // base + offset for LW/SW
	assign data_writedata = rt_data;

endmodule

`default_nettype wire

// ==== tb/harvard_mem_model.sv ====
`default_nettype none

module harvard_mem_model #(
	parameter int ROM_WORDS = 64,
	parameter int RAM_WORDS = 256
) (
	input  logic        clk,
	input  logic        reset,
	input  logic        clk_enable,
	input  logic [31:0] instr_address,
	output logic [31:0] instr_readdata,
	input  logic [31:0] data_address,
	input  logic        data_write,
	input  logic        data_read,
	input  logic [31:0] data_writedata,
	output logic [31:0] data_readdata
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int ROM_AW = $clog2(ROM_WORDS);
	localparam int RAM_AW = $clog2(RAM_WORDS);

	logic [31:0] rom [ROM_WORDS]; // Program loaded from outside during reset
	logic [31:0] ram [RAM_WORDS];

	// Word index only, boot region offset falls away in the upper bits
	assign instr_readdata = rom[instr_address[ROM_AW+1:2]];
	assign data_readdata  = data_read ? ram[data_address[RAM_AW+1:2]] : 32'h0;

	always @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < RAM_WORDS; i++)
				ram[i] <= 32'hDA7A0000 | (i << 2); // Fill tagged with byte address
		end else if (clk_enable && data_write) begin
			ram[data_address[RAM_AW+1:2]] <= data_writedata; // Only on enabled edge
		end
	end

endmodule

`default_nettype wire

// ==== tb/tb_mips_cpu.sv ====
`default_nettype none

module tb_mips_cpu;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int    MAX_CASES = 16;
	localparam int    MAX_WORDS = 64;
	localparam string CASE_FILE = "tb/cpu_cases.txt";

	logic        clk;
	logic        reset;
	logic        clk_enable;
	logic        active;
	logic [31:0] register_v0;
	logic [31:0] instr_address;
	logic [31:0] instr_readdata;
	logic [31:0] data_address;
	logic        data_write;
	logic        data_read;
	logic [31:0] data_writedata;
	logic [31:0] data_readdata;

	string       case_name [MAX_CASES];
	bit          case_stall [MAX_CASES]; // Also run with random stalls
	int          case_len [MAX_CASES];
	logic [31:0] case_prog [MAX_CASES][MAX_WORDS];
	logic [31:0] exp_v0 [MAX_CASES];
	logic [31:0] exp_addr [MAX_CASES];
	logic [31:0] exp_data [MAX_CASES];

	int num_cases;
	int total_words; // Sizes the watchdog
	int run_errors;
	int runs_passed;
	int runs_failed;
	int seed = 32'h4f80310a;
	int stall_draw;
	bit stall_on;
	bit post_halt_strobe;
	bit cases_ok;
	bit loaded;
	bit aborted;

	mips_cpu_harvard u_dut (
		.clk            (clk),
		.reset          (reset),
		.active         (active),
		.register_v0    (register_v0),
		.clk_enable     (clk_enable),
		.instr_address  (instr_address),
		.instr_readdata (instr_readdata),
		.data_address   (data_address),
		.data_write     (data_write),
		.data_read      (data_read),
		.data_writedata (data_writedata),
		.data_readdata  (data_readdata)
	);

	harvard_mem_model #(.ROM_WORDS(MAX_WORDS)) u_mem (
		.clk            (clk),
		.reset          (reset),
		.clk_enable     (clk_enable),
		.instr_address  (instr_address),
		.instr_readdata (instr_readdata),
		.data_address   (data_address),
		.data_write     (data_write),
		.data_read      (data_read),
		.data_writedata (data_writedata),
		.data_readdata  (data_readdata)
	);

	always #2 clk = ~clk; // 4 ns period

	always @(posedge clk) begin
		#0.5;
		if (stall_on) begin
			stall_draw = $random(seed);
			clk_enable = (stall_draw[1:0] != 2'b00); // About one stall in four
		end else begin
			clk_enable = 1'b1;
		end
	end

	always @(negedge clk)
		if (!reset && !active && (data_write || data_read))
			post_halt_strobe = 1'b1; // Latched until next reset

	// Skips '#' comments up to end of line
	function automatic string next_token(input int fd);
		string tok;
		string rest;
		int n;
		tok = "";
		while (tok == "" && !$feof(fd)) begin
			n = $fscanf(fd, "%s", tok);
			if (n == 1 && tok.substr(0, 0) == "#") begin
				n = $fgets(rest, fd);
				tok = "";
			end
		end
		return tok;
	endfunction

	function automatic logic [31:0] hex_value(input string tok);
		logic [31:0] v;
		int n;
		v = 'x;
		n = $sscanf(tok, "%h", v);
		return v;
	endfunction

	task automatic load_cases(output bit ok);
		int fd;
		string tok;
		ok = 1'b0;
		fd = $fopen(CASE_FILE, "r");
		if (fd == 0) begin
			$display("Cannot open case file %s", CASE_FILE);
			return;
		end
		tok = next_token(fd);
		while (tok == "case" && num_cases < MAX_CASES) begin
			case_name[num_cases] = next_token(fd);
			case_stall[num_cases] = (next_token(fd) == "1");
			tok = next_token(fd);
			case_len[num_cases] = tok.atoi();
			for (int i = 0; i < case_len[num_cases] && i < MAX_WORDS; i++)
				case_prog[num_cases][i] = hex_value(next_token(fd));
			exp_v0[num_cases] = hex_value(next_token(fd));
			exp_addr[num_cases] = hex_value(next_token(fd));
			exp_data[num_cases] = hex_value(next_token(fd));
			total_words += case_len[num_cases] * (case_stall[num_cases] ? 2 : 1);
			num_cases++;
			tok = next_token(fd);
		end
		$fclose(fd);
		ok = (num_cases > 0 && tok == ""); // Leftover token means a malformed case
	endtask

	task automatic report_mismatch(input string sig, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("Mismatch at %0t: %s expected %h, got %h", $time, sig, expected, actual);
		run_errors++;
	endtask

	task automatic report_failure(input string what);
		$display("%0t: %s", $time, what);
		run_errors++;
	endtask

	task automatic run_case(input int c, input bit stalled);
		int cycles;
		logic [31:0] word;
		run_errors = 0;
		@(posedge clk);
		#0.5;
		reset = 1'b1;
		post_halt_strobe = 1'b0;
		for (int i = 0; i < MAX_WORDS; i++)
			u_mem.rom[i] = (i < case_len[c]) ? case_prog[c][i] : 32'h0; // Tail is NOPs
		@(negedge clk);
		stall_on = stalled; // Away from the drive edge
		repeat (8) @(posedge clk);
		#0.5;
		reset = 1'b0;
		cycles = 0;
		while (active && cycles < case_len[c] * 64) begin
			@(negedge clk);
			cycles++;
		end
		assert (!active)
			else report_failure($sformatf("%s never halted within %0d cycles",
				case_name[c], cycles));
		if (!active) begin
			assert (instr_address == 32'h0)
				else report_mismatch("instr_address", 32'h0, instr_address);
			assert (register_v0 == exp_v0[c])
				else report_mismatch("register_v0", exp_v0[c], register_v0);
			for (int i = 0; i < 10; i++) begin
				@(posedge clk);
				#0.5;
				u_mem.rom[0] = (i % 2 == 0) ? 32'h8C020000 : 32'hAC020000; // lw, sw $2 at halt address
				@(negedge clk);
				assert (!active)
					else report_failure("active rose again after the halt");
				assert (register_v0 == exp_v0[c])
					else report_mismatch("register_v0", exp_v0[c], register_v0);
			end
			word = u_mem.ram[exp_addr[c][9:2]];
			assert (word == exp_data[c])
				else report_mismatch($sformatf("ram[%h]", exp_addr[c]), exp_data[c], word);
			assert (!post_halt_strobe)
				else report_failure("a data strobe was raised after the core halted");
		end
		if (run_errors == 0)
			runs_passed++;
		else
			runs_failed++;
		$display("%s, %s: %s (%0d errors)", case_name[c],
			stalled ? "random stalls" : "no stalls", run_errors == 0 ? "ok" : "failed", run_errors);
	endtask

	task automatic report_and_finish;
		$display("Runs: %0d passed, %0d failed", runs_passed, runs_failed);
		if (runs_failed == 0 && !aborted)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	endtask

	initial begin
		wait (loaded);
		#(total_words * 64 * 4); // 64 cycles of 4 ns per program word
		$display("Watchdog expired at %0t, the run did not finish", $time);
		aborted = 1'b1;
		report_and_finish();
	end

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		clk_enable = 1'b1;
		stall_on = 1'b0;
		load_cases(cases_ok);
		if (!cases_ok) begin
			$display("Case file could not be read completely");
			aborted = 1'b1;
		end else begin
			loaded = 1'b1;
			for (int c = 0; c < num_cases; c++) begin
				run_case(c, 1'b0);
				if (case_stall[c])
					run_case(c, 1'b1); // Same expected values under stalls
			end
		end
		report_and_finish();
	end

endmodule

`default_nettype wire

// ==== tb/cpu_cases.txt ====
# case <name> <stall: 1 = also run with random clk_enable> <word count>, then program words,
# then expected v0, checked data address and expected word there (all hex)
case alu 1 23
3C081234 35085678 2409FFF0 00095083 00095F02 010B1023  # lui ori addiu sra srl subu
004A1026 014B402A 014B482B 01685804 004B1021 2D48FFFF  # xor slt sltu sllv addu sltiu
3049FF00 292AFFFF 384200FF 00481021 00491021 01025807  # andi slti xori addu addu srav
004B1024 01024806 00094A00 00491026 00000008           # and srlv sll xor, jr $0
86C41021 00000080 DA7A0080                             # untouched fill word

case mem 1 9
24080040 3C09CAFE 3529F00D AD090008 8D020008  # base 0x40, sw then lw into v0
8D0A0000 004A1021 AD02FFFC 00000008           # lw fill word, addu, sw at 0x3c
A578F04D 0000003C A578F04D

case branch 0 30
2408FFFD 24090005 11080001 24420001 11090001 24420002  # beq taken, beq not
15090001 24420004 15290001 24420008 19000001 24420010  # bne taken, bne not, blez taken
19200001 24420020 1D200001 24420040 1C000001 24420080  # blez not, bgtz taken, bgtz not
05000001 24420100 05200001 24420200 04010001 24420400  # bltz taken, bltz not, bgez taken
05010001 24420800 10000002 24421000 24422000 00000008  # bgez not, skip two, jr $0
00000AAA 00000080 DA7A0080

case link 1 19
0FF0000C 24420001 2408FFFF 0510000A 05110001  # jal sub1, bltzal sub2, bgezal not taken
005F1021 04110007 3C09BFC0 35290040 0120F809  # v0 += ra, bgezal sub2, jalr sub3
0BF00012 24427000 24420010 03E00008 24420100  # j done, skipped, sub1, sub2
03E00008 005F1021 03E00008 00000008           # sub3 adds ra, done
7F80024D 00000084 DA7A0084

// ==== vlog.f ====
+incdir+include
verilog/mips_isa_pkg.sv
verilog/cpu_ctrl_pkg.sv
verilog/instr_decoder.sv
verilog/register_file.sv
verilog/execute_unit.sv
verilog/commit_unit.sv
verilog/mips_cpu_harvard.sv
tb/harvard_mem_model.sv
tb/tb_mips_cpu.sv
